//--- sim.f
common/pkt_buf_pkg.sv
verilog/desc_alloc.sv
verilog/pkt_buffer_mem.sv
packet_write/packet_write.sv
verilog/pkt_buf_top.sv
test/tb_pkt_buf.sv

//--- Makefile
TOP := tb_pkt_buf

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv --timescale 1ns/1ps \
		--top-module $(TOP) -f sim.f -Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf obj_dir

//--- test/tb_pkt_buf.sv
`timescale 1ns/1ps

module tb_pkt_buf
    import pkt_buf_pkg::*;
;

    localparam int DATA_BYTES   = 8;
    localparam int ADDR_WID     = 8;
    localparam int MIN_PKT_SIZE = 40;
    localparam int MAX_PKT_SIZE = 200;
    localparam bit DROP_ERRORED = 1'b1;

    localparam int DEPTH     = 1 << ADDR_WID;
    localparam int BYTES_WID = $clog2(DATA_BYTES + 1);
    localparam int MAX_WORDS = (MAX_PKT_SIZE + DATA_BYTES - 1) / DATA_BYTES;
    localparam int OUT_KEEP  = 4;
    // Packet count rounded up to cover the two buffer readbacks
    localparam int NUM_PKTS  = 100;
    localparam int LIMIT_NS  = NUM_PKTS * (MAX_WORDS + 4) * 8 + 2000;

    typedef struct packed {
        logic                keep;
        drop_status_e        status;
        logic [ADDR_WID-1:0] addr;
        size_t               size;
        meta_t               meta;
        logic                err;
    } expect_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    in_valid;
    logic                    in_sop;
    logic                    in_eop;
    logic [DATA_BYTES*8-1:0] in_data;
    logic [BYTES_WID-1:0]    in_bytes;
    logic                    in_err;
    meta_t                   in_meta;
    logic                    rel_valid;
    words_t                  rel_words;
    logic [ADDR_WID-1:0]     rd_addr;
    logic [DATA_BYTES*8-1:0] rd_data;
    logic                    desc_valid;
    logic [ADDR_WID-1:0]     desc_addr;
    size_t                   desc_size;
    meta_t                   desc_meta;
    logic                    desc_err;
    logic                    drop_valid;
    drop_status_e            drop_status;

    // Reference model state
    int                      seed = 32'h4f07;
    int                      model_head;
    int                      model_tail;
    int                      model_used;
    int                      kept_words_total;
    int                      last_outcome;
    int                      kept_q[$];
    expect_t                 exp_q[$];
    expect_t                 exp_e;
    logic [DATA_BYTES*8-1:0] exp_mem [DEPTH];
    bit                      exp_vld [DEPTH];

    int                      err_cnt;
    int                      base_err;
    int                      test_num;
    int                      pass_cnt;
    int                      fail_cnt;

    always #4 clk = ~clk;

    pkt_buf_top #(
        .DATA_BYTES   (DATA_BYTES),
        .ADDR_WID     (ADDR_WID),
        .MIN_PKT_SIZE (MIN_PKT_SIZE),
        .MAX_PKT_SIZE (MAX_PKT_SIZE),
        .DROP_ERRORED (DROP_ERRORED)
    ) i_pkt_buf_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_sop      (in_sop),
        .in_eop      (in_eop),
        .in_data     (in_data),
        .in_bytes    (in_bytes),
        .in_err      (in_err),
        .in_meta     (in_meta),
        .rel_valid   (rel_valid),
        .rel_words   (rel_words),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .desc_valid  (desc_valid),
        .desc_addr   (desc_addr),
        .desc_size   (desc_size),
        .desc_meta   (desc_meta),
        .desc_err    (desc_err),
        .drop_valid  (drop_valid),
        .drop_status (drop_status)
    );

    // ========================================
    // Reference model
    // ========================================

    function automatic int words_of(input int len);
        return (len + DATA_BYTES - 1) / DATA_BYTES;
    endfunction

    // Outcome of one packet in the write stage's priority order
    function automatic int classify_pkt(input int len, input bit err, input int free_words,
                                        input bit drop_errored, output int exp_addr,
                                        output int exp_size);
        int cap;
        cap      = (free_words < MAX_WORDS) ? free_words : MAX_WORDS;
        exp_addr = model_head;
        exp_size = len;
        if (len > MAX_PKT_SIZE)
            return int'(DROP_LONG);
        if (len < MIN_PKT_SIZE)
            return int'(DROP_SHORT);
        if (words_of(len) > cap)
            return int'(DROP_OFLOW);
        if (err && drop_errored)
            return int'(DROP_ERR);
        return OUT_KEEP;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        int v;
        v = $random(seed);
        return lo + ((v & 32'h7fffffff) % (hi - lo + 1));
    endfunction

    // ========================================
    // Stimulus
    // ========================================

    task automatic send_pkt(input int len, input bit err);
        int                      nwords;
        int                      last_bytes;
        int                      exp_addr;
        int                      exp_size;
        int                      i;
        meta_t                   meta;
        logic [DATA_BYTES*8-1:0] w;
        expect_t                 e;
        nwords       = words_of(len);
        last_bytes   = len - DATA_BYTES * (nwords - 1);
        meta         = $random(seed);
        last_outcome = classify_pkt(len, err, DEPTH - model_used, DROP_ERRORED,
                                    exp_addr, exp_size);
        e.keep   = (last_outcome == OUT_KEEP);
        e.status = drop_status_e'(last_outcome[1:0]);
        e.addr   = ADDR_WID'(exp_addr);
        e.size   = size_t'(exp_size);
        e.meta   = meta;
        e.err    = err;
        exp_q.push_back(e);
        for (i = 0; i < nwords; i++)
        begin
            w = {$random(seed), $random(seed)};
            if (e.keep)
            begin
                exp_mem[(exp_addr + i) % DEPTH] = w;
                exp_vld[(exp_addr + i) % DEPTH] = 1'b1;
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_sop   <= (i == 0);
            in_eop   <= (i == nwords - 1);
            in_data  <= w;
            in_bytes <= BYTES_WID'((i == nwords - 1) ? last_bytes : DATA_BYTES);
            in_err   <= err;
            in_meta  <= meta;
        end
        // Two idle cycles let the allocator settle
        @(posedge clk);
        in_valid <= 1'b0;
        in_sop   <= 1'b0;
        in_eop   <= 1'b0;
        in_err   <= 1'b0;
        @(posedge clk);
        if (e.keep)
        begin
            model_head       = (model_head + nwords) % DEPTH;
            model_used       = model_used + nwords;
            kept_words_total = kept_words_total + nwords;
            kept_q.push_back(nwords);
        end
    endtask

    // Frees the oldest kept packets
    task automatic release_oldest(input int npkts);
        int sum;
        int k;
        sum = 0;
        for (k = 0; k < npkts && kept_q.size() > 0; k++)
            sum = sum + kept_q.pop_front();
        for (k = 0; k < sum; k++)
            exp_vld[(model_tail + k) % DEPTH] = 1'b0;
        model_tail = (model_tail + sum) % DEPTH;
        model_used = model_used - sum;
        @(posedge clk);
        rel_valid <= 1'b1;
        rel_words <= words_t'(sum);
        @(posedge clk);
        rel_valid <= 1'b0;
        rel_words <= '0;
        @(posedge clk);
    endtask

    // Read pipeline is two edges deep
    task automatic check_buffer();
        int a;
        for (a = 0; a < DEPTH + 2; a++)
        begin
            @(posedge clk);
            if (a >= 2 && exp_vld[a - 2] && rd_data !== exp_mem[a - 2])
            begin
                $display("FAILED %0t: buffer word %0d is %h, expected %h",
                         $time, a - 2, rd_data, exp_mem[a - 2]);
                err_cnt++;
            end
            if (a < DEPTH)
                rd_addr <= ADDR_WID'(a);
        end
    endtask

    task automatic end_test(input string name);
        repeat (2) @(posedge clk);
        if (exp_q.size() != 0)
        begin
            $display("ERROR: %0d expected outcomes were never reported", exp_q.size());
            err_cnt++;
            exp_q.delete();
        end
        test_num++;
        if (err_cnt == base_err)
        begin
            pass_cnt++;
            $display("test %0d %s: ok", test_num, name);
        end
        else
        begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", test_num, name, err_cnt - base_err);
        end
        base_err = err_cnt;
    endtask

    // ========================================
    // Compare process
    // ========================================

    always @(posedge clk)
    begin
        if (rst_n && (desc_valid || drop_valid))
        begin
            if (exp_q.size() == 0)
            begin
                if (desc_valid)
                    $display("ERROR: unexpected descriptor at %0t", $time);
                else
                    $display("ERROR: unexpected drop at %0t", $time);
                err_cnt++;
            end
            else
            begin
                exp_e = exp_q.pop_front();
                if (desc_valid && !exp_e.keep)
                begin
                    $display("FAILED %0t: descriptor, expected drop %s",
                             $time, exp_e.status.name());
                    err_cnt++;
                end
                else if (drop_valid && exp_e.keep)
                begin
                    $display("FAILED %0t: drop %s, expected descriptor",
                             $time, drop_status.name());
                    err_cnt++;
                end
                else if (drop_valid && drop_status !== exp_e.status)
                begin
                    $display("FAILED %0t: drop status %s, expected %s",
                             $time, drop_status.name(), exp_e.status.name());
                    err_cnt++;
                end
                else if (desc_valid)
                begin
                    if (desc_addr !== exp_e.addr)
                    begin
                        $display("FAILED %0t: desc_addr %0d, expected %0d",
                                 $time, desc_addr, exp_e.addr);
                        err_cnt++;
                    end
                    if (desc_size !== exp_e.size)
                    begin
                        $display("FAILED %0t: desc_size %0d, expected %0d",
                                 $time, desc_size, exp_e.size);
                        err_cnt++;
                    end
                    if (desc_meta !== exp_e.meta || desc_err !== exp_e.err)
                    begin
                        $display("FAILED %0t: desc_meta/desc_err %h/%b, expected %h/%b",
                                 $time, desc_meta, desc_err, exp_e.meta, exp_e.err);
                        err_cnt++;
                    end
                end
            end
        end
    end

    initial
    begin
        #(LIMIT_NS);
        $display("ERROR: run timed out after %0d ns", LIMIT_NS);
        $display("Test failed");
        $finish;
    end

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        int n;
        int len;
        int kind;
        int since_rel;
        int words_base;
        int a;
        int s;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_sop    = 1'b0;
        in_eop    = 1'b0;
        in_data   = '0;
        in_bytes  = '0;
        in_err    = 1'b0;
        in_meta   = '0;
        rel_valid = 1'b0;
        rel_words = '0;
        rd_addr   = '0;
        for (n = 0; n < DEPTH; n++)
            exp_vld[n] = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Short enough that ten always fit
        for (n = 0; n < 10; n++)
            send_pkt(rand_range(MIN_PKT_SIZE, 120), 1'b0);
        check_buffer();
        end_test("single packets");

        send_pkt(MIN_PKT_SIZE - 1, 1'b0);
        send_pkt(MAX_PKT_SIZE + 1, 1'b0);
        send_pkt(rand_range(MIN_PKT_SIZE, MAX_PKT_SIZE), 1'b0);
        end_test("length limits");

        if (classify_pkt(96, 1'b1, DEPTH - model_used, 1'b0, a, s) != OUT_KEEP)
        begin
            $display("ERROR: model drops an errored packet with error dropping off");
            err_cnt++;
        end
        send_pkt(96, 1'b1);
        end_test("errored packet");

        len = rand_range(120, MAX_PKT_SIZE);
        while (words_of(len) <= DEPTH - model_used)
        begin
            send_pkt(len, 1'b0);
            len = rand_range(120, MAX_PKT_SIZE);
        end
        send_pkt(len, 1'b0);
        while (words_of(len) > DEPTH - model_used)
            release_oldest(1);
        send_pkt(len, 1'b0);
        end_test("overflow");

        release_oldest(kept_q.size());
        words_base = kept_words_total;
        since_rel  = 0;
        for (n = 0; n < 50; n++)
        begin
            kind = rand_range(0, 7);
            if (kind == 0)
                send_pkt(rand_range(1, MIN_PKT_SIZE - 1), 1'b0);
            else if (kind == 1)
                send_pkt(rand_range(MAX_PKT_SIZE + 1, MAX_PKT_SIZE + 40), 1'b0);
            else
                send_pkt(rand_range(MIN_PKT_SIZE, MAX_PKT_SIZE), kind == 2);
            if (last_outcome == OUT_KEEP)
                since_rel++;
            if (since_rel == 3)
            begin
                release_oldest(3);
                since_rel = 0;
            end
        end
        if (kept_words_total - words_base <= DEPTH)
        begin
            $display("ERROR: head never wrapped past the buffer end");
            err_cnt++;
        end
        check_buffer();
        end_test("stream with wrap");

        $display("tests run %0d, passed %0d, failed %0d", test_num, pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- verilog/pkt_buf_top.sv
`timescale 1ns/1ps

module pkt_buf_top
    import pkt_buf_pkg::*;
#(
    parameter int DATA_BYTES   = 8,
    parameter int ADDR_WID     = 8,
    parameter int MIN_PKT_SIZE = 40,
    parameter int MAX_PKT_SIZE = 200,
    parameter bit DROP_ERRORED = 1'b1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // Packet input
    input  logic                            in_valid,
    input  logic                            in_sop,
    input  logic                            in_eop,
    input  logic [DATA_BYTES*8-1:0]         in_data,
    input  logic [$clog2(DATA_BYTES+1)-1:0] in_bytes,
    input  logic                            in_err,
    input  meta_t                           in_meta,
    // Space release
    input  logic                            rel_valid,
    input  words_t                          rel_words,
    // Buffer read
    input  logic [ADDR_WID-1:0]             rd_addr,
    output logic [DATA_BYTES*8-1:0]         rd_data,
    // Completion report
    output logic                            desc_valid,
    output logic [ADDR_WID-1:0]             desc_addr,
    output size_t                           desc_size,
    output meta_t                           desc_meta,
    output logic                            desc_err,
    output logic                            drop_valid,
    output drop_status_e                    drop_status
);

    localparam int DATA_WID = DATA_BYTES * 8;

    logic [ADDR_WID-1:0] nxt_addr;
    words_t              nxt_words;

    logic                mem_wr_en;
    logic [ADDR_WID-1:0] mem_wr_addr;
    logic [DATA_WID-1:0] mem_wr_data;

    // ========================================
    // Allocator
    // ========================================

    desc_alloc #(
        .DATA_BYTES   (DATA_BYTES),
        .ADDR_WID     (ADDR_WID),
        .MAX_PKT_SIZE (MAX_PKT_SIZE)
    ) i_desc_alloc (
        .clk        (clk),
        .rst_n      (rst_n),
        .desc_valid (desc_valid),
        .desc_size  (desc_size),
        .rel_valid  (rel_valid),
        .rel_words  (rel_words),
        .nxt_addr   (nxt_addr),
        .nxt_words  (nxt_words)
    );

    // ========================================
    // Write stage and buffer
    // ========================================

    packet_write #(
        .DATA_BYTES   (DATA_BYTES),
        .ADDR_WID     (ADDR_WID),
        .MIN_PKT_SIZE (MIN_PKT_SIZE),
        .MAX_PKT_SIZE (MAX_PKT_SIZE),
        .DROP_ERRORED (DROP_ERRORED)
    ) i_packet_write (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_sop      (in_sop),
        .in_eop      (in_eop),
        .in_data     (in_data),
        .in_bytes    (in_bytes),
        .in_err      (in_err),
        .in_meta     (in_meta),
        .nxt_addr    (nxt_addr),
        .nxt_words   (nxt_words),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .desc_valid  (desc_valid),
        .desc_addr   (desc_addr),
        .desc_size   (desc_size),
        .desc_meta   (desc_meta),
        .desc_err    (desc_err),
        .drop_valid  (drop_valid),
        .drop_status (drop_status)
    );

    pkt_buffer_mem #(
        .ADDR_WID (ADDR_WID),
        .DATA_WID (DATA_WID)
    ) i_pkt_buffer_mem (
        .clk     (clk),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- packet_write/packet_write.sv
`timescale 1ns/1ps

module packet_write
    import pkt_buf_pkg::*;
#(
    parameter int DATA_BYTES   = 8,
    parameter int ADDR_WID     = 8,
    parameter int MIN_PKT_SIZE = 40,
    parameter int MAX_PKT_SIZE = 200,
    parameter bit DROP_ERRORED = 1'b1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // Packet input with one word per cycle
    input  logic                            in_valid,
    input  logic                            in_sop,
    input  logic                            in_eop,
    input  logic [DATA_BYTES*8-1:0]         in_data,
    input  logic [$clog2(DATA_BYTES+1)-1:0] in_bytes,
    input  logic                            in_err,
    input  meta_t                           in_meta,
    // Offer from the allocator
    input  logic [ADDR_WID-1:0]             nxt_addr,
    input  words_t                          nxt_words,
    // Buffer write port
    output logic                            mem_wr_en,
    output logic [ADDR_WID-1:0]             mem_wr_addr,
    output logic [DATA_BYTES*8-1:0]         mem_wr_data,
    // Completion report
    output logic                            desc_valid,
    output logic [ADDR_WID-1:0]             desc_addr,
    output size_t                           desc_size,
    output meta_t                           desc_meta,
    output logic                            desc_err,
    output logic                            drop_valid,
    output drop_status_e                    drop_status
);

    localparam size_t WORD_BYTES = size_t'(DATA_BYTES);
    localparam size_t MIN_SIZE   = size_t'(MIN_PKT_SIZE);
    localparam size_t MAX_SIZE   = size_t'(MAX_PKT_SIZE);

    wr_state_e           state_q;
    wr_state_e           state_d;

    // Context latched at sop
    logic [ADDR_WID-1:0] start_addr_q;
    words_t              cap_q;
    meta_t               meta_q;
    words_t              word_cnt_q;
    size_t               byte_cnt_q;

    logic                accept;
    logic [ADDR_WID-1:0] cur_start;
    words_t              cur_cap;
    words_t              cur_idx;
    words_t              new_words;
    meta_t               cur_meta;
    size_t               prev_bytes;
    size_t               word_bytes;
    size_t               new_bytes;
    logic                discarding;
    logic                too_long;
    logic                fits;
    logic                pkt_done;
    logic                drop_d;
    drop_status_e        status_d;

    // ========================================
    // Per-word view of the packet
    // ========================================

    // On the sop word the context comes straight from the inputs,
    // so a single-word packet needs no special path
    always_comb
    begin
        accept     = in_valid && (in_sop || state_q != ST_IDLE);
        cur_start  = in_sop ? nxt_addr : start_addr_q;
        cur_cap    = in_sop ? nxt_words : cap_q;
        cur_meta   = in_sop ? in_meta : meta_q;
        cur_idx    = in_sop ? '0 : word_cnt_q;
        prev_bytes = in_sop ? '0 : byte_cnt_q;
        discarding = !in_sop && state_q == ST_DISCARD;

        word_bytes = in_eop ? size_t'(in_bytes) : WORD_BYTES;
        new_bytes  = prev_bytes + word_bytes;
        new_words  = cur_idx + words_t'(1);

        too_long   = discarding || new_bytes > MAX_SIZE;
        // Word index still inside the space offered at sop
        fits       = cur_idx < cur_cap;
        pkt_done   = accept && in_eop;
    end

    // Outcome at eop with the highest priority first
    always_comb
    begin
        drop_d   = 1'b1;
        status_d = DROP_LONG;
        if (too_long)
            status_d = DROP_LONG;
        else if (new_bytes < MIN_SIZE)
            status_d = DROP_SHORT;
        else if (new_words > cur_cap)
            status_d = DROP_OFLOW;
        else if (in_err && DROP_ERRORED)
            status_d = DROP_ERR;
        else
            drop_d = 1'b0;
    end

    // ========================================
    // FSM
    // ========================================

    always_comb
    begin
        state_d = state_q;
        if (accept)
        begin
            if (in_eop)
                state_d = ST_IDLE;
            else if (too_long)
                state_d = ST_DISCARD;
            else
                state_d = ST_WRITE;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q    <= ST_IDLE;
            mem_wr_en  <= 1'b0;
            desc_valid <= 1'b0;
            drop_valid <= 1'b0;
        end
        else
        begin
            state_q    <= state_d;
            mem_wr_en  <= accept && !too_long && fits;
            desc_valid <= pkt_done && !drop_d;
            drop_valid <= pkt_done && drop_d;
        end
    end

    // Counters freeze once the packet is known to be too long
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            start_addr_q <= cur_start;
            cap_q        <= cur_cap;
            meta_q       <= cur_meta;
            if (!too_long)
            begin
                word_cnt_q <= new_words;
                byte_cnt_q <= new_bytes;
            end
        end

        // Address wraps at the buffer end
        mem_wr_addr <= cur_start + cur_idx[ADDR_WID-1:0];
        mem_wr_data <= in_data;

        if (pkt_done)
        begin
            desc_addr   <= cur_start;
            desc_size   <= new_bytes;
            desc_meta   <= cur_meta;
            desc_err    <= in_err;
            drop_status <= status_d;
        end
    end

    // ========================================
    // Assertions
    // ========================================

    a_eop_bytes: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_eop |-> in_bytes != '0)
        else $error("eop word with zero valid bytes");

    a_no_nested_sop: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && state_q != ST_IDLE |-> !in_sop)
        else $error("sop while a packet is in progress");

endmodule

//--- verilog/pkt_buffer_mem.sv
`timescale 1ns/1ps

module pkt_buffer_mem #(
    parameter int ADDR_WID = 8,
    parameter int DATA_WID = 64
) (
    input  logic                clk,
    // Write port
    input  logic                wr_en,
    input  logic [ADDR_WID-1:0] wr_addr,
    input  logic [DATA_WID-1:0] wr_data,
    // Read port, data one cycle after address
    input  logic [ADDR_WID-1:0] rd_addr,
    output logic [DATA_WID-1:0] rd_data
);

    localparam int DEPTH = 1 << ADDR_WID;

    logic [DATA_WID-1:0] mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

    // An X address would corrupt an unknown location
    a_wr_addr_known: assert property (@(posedge clk)
        wr_en |-> !$isunknown(wr_addr))
        else $error("buffer write with unknown address");

endmodule

//--- verilog/desc_alloc.sv
`timescale 1ns/1ps

module desc_alloc
    import pkt_buf_pkg::*;
#(
    parameter int DATA_BYTES   = 8,
    parameter int ADDR_WID     = 8,
    parameter int MAX_PKT_SIZE = 200
) (
    input  logic                clk,
    input  logic                rst_n,
    // Completed packet from the write stage
    input  logic                desc_valid,
    input  size_t               desc_size,
    // Space returned by the consumer
    input  logic                rel_valid,
    input  words_t              rel_words,
    // Offer for the next packet
    output logic [ADDR_WID-1:0] nxt_addr,
    output words_t              nxt_words
);

    localparam int     DEPTH     = 1 << ADDR_WID;
    localparam int     SIZE_WID  = $bits(size_t) + 1;
    localparam int     FREE_WID  = $bits(words_t) + 1;
    localparam words_t MAX_WORDS = words_t'((MAX_PKT_SIZE + DATA_BYTES - 1) / DATA_BYTES);

    localparam logic [FREE_WID-1:0] DEPTH_W = FREE_WID'(DEPTH);

    logic [ADDR_WID-1:0] head_q;
    words_t              used_q;

    logic [SIZE_WID-1:0] size_round;
    words_t              pkt_words;
    logic [FREE_WID-1:0] free_words;

    // Bytes to words, rounded up
    assign size_round = {1'b0, desc_size} + SIZE_WID'(DATA_BYTES - 1);
    assign pkt_words  = words_t'(size_round / SIZE_WID'(DATA_BYTES));

    // ========================================
    // Head and occupancy
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            head_q <= '0;
            used_q <= '0;
        end
        else
        begin
            if (desc_valid)
                head_q <= head_q + pkt_words[ADDR_WID-1:0];
            // A descriptor and a release can land on the same cycle
            used_q <= used_q
                      + (desc_valid ? pkt_words : '0)
                      - (rel_valid ? rel_words : '0);
        end
    end

    // Offer never more than one maximum packet needs
    assign free_words = DEPTH_W - {1'b0, used_q};
    assign nxt_addr   = head_q;
    assign nxt_words  = (free_words > {1'b0, MAX_WORDS}) ? MAX_WORDS
                                                         : free_words[FREE_WID-2:0];

    a_rel_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        rel_valid |-> rel_words <= used_q)
        else $error("release of %0d words exceeds %0d used", rel_words, used_q);

endmodule

//--- common/pkt_buf_pkg.sv
package pkt_buf_pkg;

    // ========================================
    // Payload types
    // ========================================

    // Metadata carried from the sop word through to the descriptor
    typedef logic [31:0] meta_t;

    // Packet length in bytes
    typedef logic [15:0] size_t;

    // Count of buffer words
    // Used for free space, capacity and release counts
    typedef logic [15:0] words_t;

    // ========================================
    // Status and state encodings
    // ========================================

    // Reason reported with drop_valid
    typedef enum logic [1:0] {
        DROP_SHORT = 2'd0,
        DROP_LONG  = 2'd1,
        DROP_ERR   = 2'd2,
        DROP_OFLOW = 2'd3
    } drop_status_e;

    // Write stage FSM
    // ST_DISCARD swallows the rest of an oversize packet
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_WRITE   = 2'd1,
        ST_DISCARD = 2'd2
    } wr_state_e;

endpackage
